// File: src.f
+incdir+hdl
hdl/uart_line_pkg.sv
hdl/uart_fifo_pkg.sv
hdl/uart_rx.sv
hdl/uart_rx_fifo.sv
hdl/uart_tx.sv
hdl/esp_uart.sv
tests/esp_uart_tb.sv

// File: tests/esp_uart_tb.sv
// Testbench for the UART top; assumes UART_CLK_PER_BIT is even and at least 4, fixed random seed
`timescale 1ns/1ns
`include "uart_settings.svh"

module esp_uart_tb;

    localparam int bit_cycles = `UART_CLK_PER_BIT;
    localparam int wait_limit = 40 * `UART_CLK_PER_BIT;

    logic                      clk;
    logic                      reset;
    uart_line_pkg::uart_byte_t tx_data;
    logic                      tx_valid;
    logic                      tx_break;
    logic                      rxfifo_read;
    logic                      uart_rxd;
    logic                      uart_cts;
    logic                      tx_busy;
    uart_line_pkg::uart_byte_t rxfifo_data;
    logic                      rxfifo_not_empty;
    logic                      rxfifo_overflow;
    logic                      rx_framing_error;
    logic                      rx_break;
    logic                      uart_txd;
    logic                      uart_rts;

    uart_line_pkg::uart_byte_t exp_q[$];
    uart_line_pkg::uart_byte_t exp_b;
    uart_line_pkg::uart_byte_t b;
    logic                      rd_seen;
    int                        errors;
    int                        tests_run;
    int                        tests_failed;
    int                        ovf_seen;
    int                        fe_seen;
    int                        brk_seen;
    int                        err0;
    int                        ovf0;
    int                        fe0;
    int                        brk0;
    int                        bad;

    esp_uart i_dut (
        .clk              (clk),
        .reset            (reset),
        .tx_data          (tx_data),
        .tx_valid         (tx_valid),
        .tx_break         (tx_break),
        .rxfifo_read      (rxfifo_read),
        .uart_rxd         (uart_rxd),
        .uart_cts         (uart_cts),
        .tx_busy          (tx_busy),
        .rxfifo_data      (rxfifo_data),
        .rxfifo_not_empty (rxfifo_not_empty),
        .rxfifo_overflow  (rxfifo_overflow),
        .rx_framing_error (rx_framing_error),
        .rx_break         (rx_break),
        .uart_txd         (uart_txd),
        .uart_rts         (uart_rts)
    );

    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 8N1 frame, bit 0 is the start bit and goes on the wire first
    function automatic logic [9:0] frame_of(input uart_line_pkg::uart_byte_t data);
        return {1'b1, data, 1'b0};
    endfunction

    task automatic flag_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", wait_limit, what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("Test %s finished with %0d errors", name, errors - err_before);
    endtask

    // Called on a falling edge, leaves the line idle for idle_bits afterwards
    task automatic drive_frame(input logic [9:0] frame, input int idle_bits);
        for (int i = 0; i < 10; i++) begin
            uart_rxd = frame[i];
            repeat (bit_cycles) @(negedge clk);
        end
        uart_rxd = 1'b1;
        repeat (idle_bits * bit_cycles) @(negedge clk);
    endtask

    task automatic read_fifo_byte();
        int n = 0;
        while (!rxfifo_not_empty && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!rxfifo_not_empty) begin
            report_timeout("data in the receive FIFO");
        end else begin
            rxfifo_read = 1'b1;
            @(negedge clk);
            rxfifo_read = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic send_tx_byte(input uart_line_pkg::uart_byte_t data);
        tx_data  = data;
        tx_valid = 1'b1;
        @(negedge clk);
        tx_valid = 1'b0;
    endtask

    // Finds the start bit, then samples every bit at its middle
    task automatic capture_tx_frame(output logic [9:0] frame);
        int n = 0;
        frame = '1;
        while (uart_txd && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (uart_txd) begin
            report_timeout("a start bit on uart_txd");
        end else begin
            repeat (bit_cycles / 2 - 1) @(negedge clk);
            frame[0] = uart_txd;
            for (int i = 1; i < 10; i++) begin
                repeat (bit_cycles) @(negedge clk);
                frame[i] = uart_txd;
            end
        end
    endtask

    task automatic wait_tx_idle();
        int n = 0;
        while (tx_busy && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (tx_busy) begin
            report_timeout("tx_busy to fall");
        end
    endtask

    task automatic check_tx_byte(input uart_line_pkg::uart_byte_t data);
        logic [9:0] got;
        capture_tx_frame(got);
        if (got !== frame_of(data)) begin
            flag_error($sformatf("uart_txd frame %b, expected %b", got, frame_of(data)));
        end
        wait_tx_idle();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read data checker and pulse counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        rd_seen <= rxfifo_read;
    end

    // Sampled mid-cycle, where the registered read data and pulses are stable
    always @(negedge clk) begin
        if (rd_seen === 1'b1) begin
            if (exp_q.size() == 0) begin
                flag_error("rxfifo_read gave a byte that was never sent");
            end else begin
                exp_b = exp_q.pop_front();
                if (rxfifo_data !== exp_b) begin
                    flag_error($sformatf("rxfifo_data %h, expected %h", rxfifo_data, exp_b));
                end
            end
        end
        if (rxfifo_overflow === 1'b1) begin
            ovf_seen++;
        end
        if (rx_framing_error === 1'b1) begin
            fe_seen++;
        end
        if (rx_break === 1'b1) begin
            brk_seen++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(32'h50d5));
        clk          = 1'b0;
        reset        = 1'b1;
        tx_data      = '0;
        tx_valid     = 1'b0;
        tx_break     = 1'b0;
        rxfifo_read  = 1'b0;
        uart_rxd     = 1'b1;
        uart_cts     = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        ovf_seen     = 0;
        fe_seen      = 0;
        brk_seen     = 0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        err0 = errors;
        if (tx_busy !== 1'b0 || rxfifo_not_empty !== 1'b0 || rxfifo_overflow !== 1'b0 ||
            rx_framing_error !== 1'b0 || rx_break !== 1'b0 || uart_rts !== 1'b0 ||
            uart_txd !== 1'b1) begin
            flag_error("outputs not at their reset values");
        end
        finish_test("reset", err0);

        err0 = errors;
        repeat (20) begin
            b = uart_line_pkg::uart_byte_t'($urandom);
            send_tx_byte(b);
            check_tx_byte(b);
        end
        finish_test("transmit", err0);

        err0 = errors;
        repeat (10) begin
            b = uart_line_pkg::uart_byte_t'($urandom);
            exp_q.push_back(b);
            drive_frame(frame_of(b), 1);
        end
        repeat (10) read_fifo_byte();
        if (exp_q.size() != 0 || rxfifo_not_empty !== 1'b0) begin
            flag_error("receive FIFO not drained after the last read");
        end
        finish_test("receive", err0);

        // The 17th byte meets a full FIFO and is not expected back
        err0 = errors;
        ovf0 = ovf_seen;
        for (int k = 1; k <= 17; k++) begin
            b = uart_line_pkg::uart_byte_t'($urandom);
            if (k <= 16) begin
                exp_q.push_back(b);
            end
            drive_frame(frame_of(b), 1);
            if (uart_rts !== (k >= 12)) begin
                flag_error($sformatf("uart_rts %b with %0d bytes sent", uart_rts, k));
            end
            if (ovf_seen - ovf0 != ((k == 17) ? 1 : 0)) begin
                flag_error($sformatf("%0d overflow pulses after %0d bytes", ovf_seen - ovf0, k));
            end
        end
        repeat (16) read_fifo_byte();
        if (exp_q.size() != 0 || rxfifo_not_empty !== 1'b0) begin
            flag_error("receive FIFO not drained after 16 reads");
        end
        finish_test("FIFO limits", err0);

        err0 = errors;
        fe0  = fe_seen;
        brk0 = brk_seen;
        drive_frame({1'b0, 8'ha5, 1'b0}, 2);
        if (fe_seen - fe0 != 1 || rxfifo_not_empty !== 1'b0) begin
            flag_error($sformatf("%0d framing error pulses, FIFO not empty %b",
                                 fe_seen - fe0, rxfifo_not_empty));
        end
        drive_frame(10'b0, 2);
        if (brk_seen - brk0 != 1 || fe_seen - fe0 != 1 || rxfifo_not_empty !== 1'b0) begin
            flag_error($sformatf("%0d break pulses after an all-low frame", brk_seen - brk0));
        end
        finish_test("line errors", err0);

        err0 = errors;
        bad  = 0;
        uart_cts = 1'b1;
        b = uart_line_pkg::uart_byte_t'($urandom);
        send_tx_byte(b);
        for (int i = 0; i < 30 * bit_cycles; i++) begin
            if (uart_txd !== 1'b1 || tx_busy !== 1'b1) begin
                bad++;
            end
            @(negedge clk);
        end
        if (bad != 0) begin
            flag_error($sformatf("line or busy wrong in %0d cycles while CTS was high", bad));
        end
        uart_cts = 1'b0;
        check_tx_byte(b);
        bad = 0;
        tx_break = 1'b1;
        @(negedge clk);
        repeat (4 * bit_cycles) begin
            if (uart_txd !== 1'b0 || tx_busy !== 1'b1) begin
                bad++;
            end
            @(negedge clk);
        end
        if (bad != 0) begin
            flag_error($sformatf("uart_txd not held low in %0d break cycles", bad));
        end
        tx_break = 1'b0;
        wait_tx_idle();
        if (uart_txd !== 1'b1) begin
            flag_error("uart_txd not high after break release");
        end
        finish_test("flow control and break", err0);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: hdl/esp_uart.sv
// UART top for the radio module link; host reads with plain strobes and must not read when empty
`timescale 1ns/1ns

module esp_uart (
    input  logic                      clk,
    input  logic                      reset,
    input  uart_line_pkg::uart_byte_t tx_data,
    input  logic                      tx_valid,
    input  logic                      tx_break,
    input  logic                      rxfifo_read,
    input  logic                      uart_rxd,
    input  logic                      uart_cts,
    output logic                      tx_busy,
    output uart_line_pkg::uart_byte_t rxfifo_data,
    output logic                      rxfifo_not_empty,
    output logic                      rxfifo_overflow,
    output logic                      rx_framing_error,
    output logic                      rx_break,
    output logic                      uart_txd,
    output logic                      uart_rts
);

    uart_line_pkg::uart_byte_t rx_data;
    logic                      rx_valid;
    logic                      rx_fe;
    logic                      rx_brk;
    logic                      rx_fe_q;
    logic                      rx_brk_q;
    uart_line_pkg::uart_byte_t rxfifo_rddata;
    logic                      rxfifo_empty;
    logic                      rxfifo_full;
    logic                      rxfifo_almost_full;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transmit path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    uart_tx i_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_break (tx_break),
        .uart_cts (uart_cts),
        .tx_busy  (tx_busy),
        .uart_txd (uart_txd)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receive path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    uart_rx i_rx (
        .clk           (clk),
        .reset         (reset),
        .uart_rxd      (uart_rxd),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .framing_error (rx_fe),
        .line_break    (rx_brk)
    );

    uart_rx_fifo i_rx_fifo (
        .clk         (clk),
        .reset       (reset),
        .wrdata      (rx_data),
        .wr_en       (rx_valid),
        .rd_en       (rxfifo_read),
        .rddata      (rxfifo_rddata),
        .empty       (rxfifo_empty),
        .full        (rxfifo_full),
        .almost_full (rxfifo_almost_full)
    );

    // Head of the FIFO is latched on each read strobe
    always_ff @(posedge clk) begin
        if (rxfifo_read) begin
            rxfifo_data <= rxfifo_rddata;
        end
    end

    // Error levels from the receiver become single-cycle pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_fe_q  <= 1'b0;
            rx_brk_q <= 1'b0;
        end else begin
            rx_fe_q  <= rx_fe;
            rx_brk_q <= rx_brk;
        end
    end

    assign rx_framing_error = rx_fe && !rx_fe_q;
    assign rx_break         = rx_brk && !rx_brk_q;
    assign rxfifo_not_empty = !rxfifo_empty;
    // The byte arriving on a full FIFO is lost
    assign rxfifo_overflow  = rx_valid && rxfifo_full;
    assign uart_rts         = rxfifo_almost_full;

endmodule

// File: hdl/uart_tx.sv
// UART transmitter for 8N1 frames; CTS is assumed already synchronous to clk, no parity
`timescale 1ns/1ns
`include "uart_settings.svh"

module uart_tx (
    input  logic                      clk,
    input  logic                      reset,
    input  uart_line_pkg::uart_byte_t tx_data,
    input  logic                      tx_valid,
    input  logic                      tx_break,
    input  logic                      uart_cts,
    output logic                      tx_busy,
    output logic                      uart_txd
);

    localparam uart_line_pkg::baud_count_t bit_last =
        uart_line_pkg::baud_count_t'(`UART_CLK_PER_BIT - 1);

    uart_line_pkg::tx_state_t   state;
    uart_line_pkg::baud_count_t baud_cnt;
    uart_line_pkg::bit_index_t  bit_idx;
    uart_line_pkg::uart_byte_t  shift_reg;
    logic                       pending;
    logic                       accept;
    logic                       bit_end;
    logic                       in_frame;

    // A byte is taken only from a fully idle transmitter
    assign accept   = (state == uart_line_pkg::tx_st_idle) && !pending && !tx_break && tx_valid;
    assign bit_end  = (baud_cnt == bit_last);
    assign in_frame = (state == uart_line_pkg::tx_st_start) ||
                      (state == uart_line_pkg::tx_st_data) ||
                      (state == uart_line_pkg::tx_st_stop);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= uart_line_pkg::tx_st_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            pending  <= 1'b0;
        end else begin
            baud_cnt <= (in_frame && !bit_end) ? baud_cnt + 1'b1 : '0;
            case (state)
                uart_line_pkg::tx_st_idle: begin
                    if (tx_break) begin
                        state <= uart_line_pkg::tx_st_break;
                    end else if (pending || accept) begin
                        // Hold the byte while the radio module asserts CTS
                        pending <= uart_cts;
                        if (!uart_cts) begin
                            state <= uart_line_pkg::tx_st_start;
                        end
                    end
                end
                uart_line_pkg::tx_st_start: begin
                    if (bit_end) begin
                        bit_idx <= '0;
                        state   <= uart_line_pkg::tx_st_data;
                    end
                end
                uart_line_pkg::tx_st_data: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == uart_line_pkg::bit_index_t'(7)) begin
                            state <= uart_line_pkg::tx_st_stop;
                        end
                    end
                end
                uart_line_pkg::tx_st_stop: begin
                    if (bit_end) begin
                        state <= uart_line_pkg::tx_st_idle;
                    end
                end
                default: begin
                    if (!tx_break) begin
                        state <= uart_line_pkg::tx_st_idle;
                    end
                end
            endcase
        end
    end

    // Capture on accept, then shift right at the end of each data bit
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg <= tx_data;
        end else if (state == uart_line_pkg::tx_st_data && bit_end) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    always_comb begin
        case (state)
            uart_line_pkg::tx_st_start: uart_txd = 1'b0;
            uart_line_pkg::tx_st_data:  uart_txd = shift_reg[0];
            uart_line_pkg::tx_st_break: uart_txd = 1'b0;
            default:                    uart_txd = 1'b1;
        endcase
    end

    assign tx_busy = (state != uart_line_pkg::tx_st_idle) || pending;

    a_idle_high: assert property (@(posedge clk) disable iff (reset)
        (state == uart_line_pkg::tx_st_idle) |-> uart_txd);

endmodule

// File: hdl/uart_rx_fifo.sv
// Receive FIFO with combinational head data; writes when full and reads when empty are dropped
`timescale 1ns/1ns
`include "uart_settings.svh"

module uart_rx_fifo (
    input  logic                      clk,
    input  logic                      reset,
    input  uart_line_pkg::uart_byte_t wrdata,
    input  logic                      wr_en,
    input  logic                      rd_en,
    output uart_line_pkg::uart_byte_t rddata,
    output logic                      empty,
    output logic                      full,
    output logic                      almost_full
);

    localparam uart_fifo_pkg::fifo_level_t depth =
        uart_fifo_pkg::fifo_level_t'(1 << `UART_FIFO_ADDR_BITS);
    localparam uart_fifo_pkg::fifo_level_t af_level =
        uart_fifo_pkg::fifo_level_t'(`UART_FIFO_ALMOST_FULL);

    uart_line_pkg::uart_byte_t   mem [0:(1 << `UART_FIFO_ADDR_BITS)-1];
    uart_fifo_pkg::fifo_addr_t   wr_ptr;
    uart_fifo_pkg::fifo_addr_t   rd_ptr;
    uart_fifo_pkg::fifo_level_t  count;
    logic                        do_wr;
    logic                        do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Storage array
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wrdata;
        end
    end

    // Pointers and fill level
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Read and write in the same cycle leave the level alone
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    assign rddata      = mem[rd_ptr];
    assign empty       = (count == '0);
    assign full        = (count == depth);
    assign almost_full = (count >= af_level);

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= depth);

    a_empty_full: assert property (@(posedge clk) disable iff (reset)
        !(empty && full));

endmodule

// File: hdl/uart_rx.sv
// UART receiver for 8N1 frames; the line is asynchronous and is synchronized here, no parity
`timescale 1ns/1ns
`include "uart_settings.svh"

module uart_rx (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      uart_rxd,
    output uart_line_pkg::uart_byte_t rx_data,
    output logic                      rx_valid,
    output logic                      framing_error,
    output logic                      line_break
);

    localparam uart_line_pkg::baud_count_t bit_last =
        uart_line_pkg::baud_count_t'(`UART_CLK_PER_BIT - 1);
    localparam uart_line_pkg::baud_count_t half_last =
        uart_line_pkg::baud_count_t'(`UART_CLK_PER_BIT / 2 - 1);

    logic                       rxd_meta;
    logic                       rxd_sync;
    uart_line_pkg::rx_state_t   state;
    uart_line_pkg::baud_count_t baud_cnt;
    uart_line_pkg::bit_index_t  bit_idx;
    uart_line_pkg::uart_byte_t  shift_reg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Line synchronizer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Idle line is high, so both stages come out of reset high
    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= uart_rxd;
            rxd_sync <= rxd_meta;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= uart_line_pkg::rx_st_idle;
            baud_cnt      <= '0;
            bit_idx       <= '0;
            rx_valid      <= 1'b0;
            framing_error <= 1'b0;
            line_break    <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                uart_line_pkg::rx_st_idle: begin
                    baud_cnt <= '0;
                    // Idle is only entered with the line high, so low here is a falling edge
                    if (!rxd_sync) begin
                        state <= uart_line_pkg::rx_st_start;
                    end
                end
                uart_line_pkg::rx_st_start: begin
                    if (baud_cnt == half_last) begin
                        // Recheck at mid start bit to reject short glitches
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rxd_sync ? uart_line_pkg::rx_st_idle
                                             : uart_line_pkg::rx_st_data;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_line_pkg::rx_st_data: begin
                    if (baud_cnt == bit_last) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == uart_line_pkg::bit_index_t'(7)) begin
                            state <= uart_line_pkg::rx_st_stop;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_line_pkg::rx_st_stop: begin
                    if (baud_cnt == bit_last) begin
                        baud_cnt <= '0;
                        if (rxd_sync) begin
                            rx_valid <= 1'b1;
                            state    <= uart_line_pkg::rx_st_idle;
                        end else begin
                            // A low stop bit after all-zero data is a break, not a bad byte
                            line_break    <= (shift_reg == '0);
                            framing_error <= (shift_reg != '0);
                            state         <= uart_line_pkg::rx_st_wait_idle;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    if (rxd_sync) begin
                        framing_error <= 1'b0;
                        line_break    <= 1'b0;
                        state         <= uart_line_pkg::rx_st_idle;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first and are shifted in from the top
    always_ff @(posedge clk) begin
        if (state == uart_line_pkg::rx_st_data && baud_cnt == bit_last) begin
            shift_reg <= {rxd_sync, shift_reg[7:1]};
        end
    end

    assign rx_data = shift_reg;

    a_valid_not_error: assert property (@(posedge clk) disable iff (reset)
        !(rx_valid && framing_error));

    a_valid_single: assert property (@(posedge clk) disable iff (reset)
        rx_valid |=> !rx_valid);

endmodule

// File: hdl/uart_fifo_pkg.sv
// FIFO pointer and level types; depth is 2**UART_FIFO_ADDR_BITS entries
`include "uart_settings.svh"

package uart_fifo_pkg;

    // Read and write pointers wrap naturally at the depth
    typedef logic [`UART_FIFO_ADDR_BITS-1:0] fifo_addr_t;

    // One extra bit so a full FIFO can be told from an empty one
    typedef logic [`UART_FIFO_ADDR_BITS:0] fifo_level_t;

endpackage

// File: hdl/uart_line_pkg.sv
// Serial line types; the baud counter width follows UART_CLK_PER_BIT, frames are 8N1 only
`include "uart_settings.svh"

package uart_line_pkg;

    // One data byte as carried on the wire
    typedef logic [7:0] uart_byte_t;

    // Counts clock cycles inside one bit time
    typedef logic [$clog2(`UART_CLK_PER_BIT)-1:0] baud_count_t;

    // Index of the data bit being shifted, LSB first
    typedef logic [2:0] bit_index_t;

    typedef enum logic [2:0] {
        tx_st_idle,
        tx_st_start,
        tx_st_data,
        tx_st_stop,
        tx_st_break
    } tx_state_t;

    // The receiver parks in wait_idle after a bad stop bit until the line recovers
    typedef enum logic [2:0] {
        rx_st_idle,
        rx_st_start,
        rx_st_data,
        rx_st_stop,
        rx_st_wait_idle
    } rx_state_t;

endpackage

// File: hdl/uart_settings.svh
// UART build constants; UART_CLK_PER_BIT must be at least 4 and the FIFO depth a power of two
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial line timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Clock cycles per serial bit, kept small so simulation stays short
`define UART_CLK_PER_BIT 8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receive FIFO sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Log2 of the FIFO depth, 4 gives 16 entries
`define UART_FIFO_ADDR_BITS 4

// Fill level at which RTS is raised toward the remote sender
// It should leave room for the bytes still in flight after RTS rises
`define UART_FIFO_ALMOST_FULL 12

`endif
